// ==== design/if_params.svh ====
// Build constants of the fetch stage; `include in blocks that size or reset by them
`ifndef IF_PARAMS_SVH
`define IF_PARAMS_SVH

// Prefetch queue size in words, keep it >= IF_MAX_OUTSTANDING
`define IF_QUEUE_DEPTH 2

// Bus requests that may be granted but not yet answered
`define IF_MAX_OUTSTANDING 2

`define IF_PC_ALIGN_MASK 32'hFFFF_FFFC  // Clears bits 1:0 of the boot address
`define IF_NOP_INSTR 32'h0000_0013      // addi x0, x0, 0

`endif

// ==== design/if_pkg.sv ====
// Shared types of the fetch stage; import into any block that uses them
package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Redirect source selected by the controller
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,  // Boot address, word aligned
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,  // Return to mepc
    PC_TRAP_EXC = 3'd4,  // mtvec base
    PC_TRAP_IRQ = 3'd5   // Vectored interrupt entry
  } pc_mux_e;

  // Aligner position within the fetched word stream
  typedef enum logic [1:0] {
    ALIGNED      = 2'd0,  // Next instruction starts at bit 0 of the head word
    HALF_PENDING = 2'd1,  // Next instruction starts at bit 16 of the head word
    SPLIT_WAIT   = 2'd2   // Low half of a 32-bit instruction held, waiting for its top
  } align_state_e;

  // One word returned by the instruction bus
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;   // Bus error on this word
  } instr_resp_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic        instr_valid;
    instr_resp_t instr;            // Expanded instruction
    logic [31:0] pc;
    logic        compressed;
    logic        illegal_c;        // Unsupported compressed encoding
    logic [15:0] compressed_instr; // Original halfword, for mtval
  } if_id_pipe_t;

endpackage

// ==== design/instr_trans_if.sv ====
// Transaction link between the prefetch unit and the bus adapter; instantiate in the IF stage
`timescale 1ns/100ps

interface instr_trans_if import if_pkg::*; ();

  // Request channel, accepted on trans_valid && trans_ready
  logic        trans_valid;
  logic        trans_ready;
  logic [31:0] trans_addr;   // Word aligned, stable while waiting for ready

  // Response channel, in request order, never stalled
  logic        resp_valid;
  instr_resp_t resp;

  modport requester (
    output trans_valid, trans_addr,
    input  trans_ready, resp_valid, resp
  );

  modport adapter (
    input  trans_valid, trans_addr,
    output trans_ready, resp_valid, resp
  );

endinterface

// ==== design/instr_obi_interface.sv ====
// OBI instruction bus adapter; maps fetch transactions onto req/gnt/rvalid
`timescale 1ns/100ps

module instr_obi_interface import if_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  instr_trans_if.adapter        trans,           // From the prefetch unit

  // OBI instruction bus
  output logic                  instr_req_o,
  input  logic                  instr_gnt_i,
  output logic [31:0]           instr_addr_o,
  input  logic                  instr_rvalid_i,
  input  logic [31:0]           instr_rdata_i,
  input  logic                  instr_err_i
);

  logic        req_pending_q;   // Request seen last cycle but not granted
  logic [31:0] addr_pending_q;  // Address of that request

  // OBI forbids dropping req or changing addr before gnt
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      req_pending_q <= 1'b0;
    end else begin
      req_pending_q <= instr_req_o && !instr_gnt_i;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_req_o && !instr_gnt_i) addr_pending_q <= instr_addr_o;
  end

  // Straight through, no added cycle
  assign instr_req_o  = trans.trans_valid || req_pending_q;
  assign instr_addr_o = req_pending_q ? addr_pending_q : trans.trans_addr;
  assign trans.trans_ready = instr_gnt_i;  // Grant accepts the transaction

  // Response packing
  assign trans.resp_valid = instr_rvalid_i;
  assign trans.resp       = '{rdata: instr_rdata_i, err: instr_err_i};

endmodule

// ==== design/prefetch_unit.sv ====
// Word fetcher, response queue and instruction aligner; sits between the IF stage and the bus adapter
`timescale 1ns/100ps
`include "if_params.svh"

module prefetch_unit import if_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pc_set_i,        // Redirect, flushes the stream
  input  logic [31:0]         branch_addr_i,   // Halfword aligned target
  input  logic                fetch_ready_i,
  output logic                fetch_valid_o,
  output instr_resp_t         fetch_instr_o,   // Aligned instruction, halfwords zero extended
  output logic [31:0]         fetch_pc_o,
  output logic                busy_o,
  instr_trans_if.requester    trans
);

  localparam int QD = `IF_QUEUE_DEPTH;
  localparam int MO = `IF_MAX_OUTSTANDING;
  localparam int PW = (QD > 1) ? $clog2(QD) : 1;  // Queue pointer width
  localparam int CW = $clog2(QD + 1);             // Queue fill width
  localparam int OW = $clog2(MO + 1);             // Outstanding counter width

  // Request side
  logic          fetch_en_q;     // Set by the first redirect
  logic [31:0]   fetch_addr_q;   // Next word to request
  logic          stale_q;        // Ungranted request of a flushed stream still on the bus
  logic [31:0]   stale_addr_q;
  logic [OW-1:0] out_cnt_q, out_cnt_n, disc_cnt_q, live_cnt;
  logic          room, grant, drop_resp, push, pop;

  // Queue and aligner
  instr_resp_t   q_mem [QD];
  logic [PW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CW-1:0] q_cnt_q;
  instr_resp_t   head;
  align_state_e  state_q;
  logic [31:0]   pc_q;
  logic [15:0]   half_q;         // Low half of a split 32-bit instruction
  logic          half_err_q;
  logic          lower_c, upper_c, fetch_valid, accept, split;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    return (int'(ptr) == QD - 1) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Requests and outstanding tracking
  ////////////////////////////////////////////////////////////////////////////

  assign live_cnt  = out_cnt_q - disc_cnt_q;  // Responses that will enter the queue
  assign room      = (int'(q_cnt_q) + int'(live_cnt) < QD) && (int'(out_cnt_q) < MO);
  assign trans.trans_valid = stale_q || (fetch_en_q && room);
  assign trans.trans_addr  = stale_q ? stale_addr_q : fetch_addr_q;
  assign grant     = trans.trans_valid && trans.trans_ready;
  assign drop_resp = trans.resp_valid && (disc_cnt_q != '0);  // Old stream
  assign push      = trans.resp_valid && !drop_resp && !pc_set_i;
  assign out_cnt_n = out_cnt_q + OW'(grant) - OW'(trans.resp_valid);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= '0;
      stale_q      <= 1'b0;
      stale_addr_q <= '0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
    end else begin
      out_cnt_q <= out_cnt_n;
      if (pc_set_i) begin
        fetch_en_q   <= 1'b1;
        fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
        disc_cnt_q   <= out_cnt_n;                                 // All in flight is stale
        stale_q      <= trans.trans_valid && !trans.trans_ready;  // Must stay until granted
        stale_addr_q <= trans.trans_addr;
      end else begin
        if (grant && stale_q) stale_q <= 1'b0;
        else if (grant) fetch_addr_q <= fetch_addr_q + 32'd4;
        disc_cnt_q <= disc_cnt_q + OW'(grant && stale_q) - OW'(drop_resp);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response queue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) q_mem[wr_ptr_q] <= trans.resp;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      q_cnt_q  <= '0;
    end else if (pc_set_i) begin  // Flush
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      q_cnt_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      q_cnt_q <= q_cnt_q + CW'(push) - CW'(pop);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Aligner
  ////////////////////////////////////////////////////////////////////////////

  assign head    = q_mem[rd_ptr_q];
  assign lower_c = head.rdata[1:0] != 2'b11;    // Compressed at bit 0
  assign upper_c = head.rdata[17:16] != 2'b11;  // Compressed at bit 16

  always_comb begin
    fetch_valid   = 1'b0;
    fetch_instr_o = head;
    case (state_q)
      ALIGNED: begin
        fetch_valid = q_cnt_q != '0;
        if (lower_c) fetch_instr_o.rdata = {16'h0000, head.rdata[15:0]};
      end
      HALF_PENDING: begin
        fetch_valid = (q_cnt_q != '0) && upper_c;  // 32-bit moves to SPLIT_WAIT first
        fetch_instr_o.rdata = {16'h0000, head.rdata[31:16]};
      end
      SPLIT_WAIT: begin
        fetch_valid = q_cnt_q != '0;
        fetch_instr_o.rdata = {head.rdata[15:0], half_q};
        fetch_instr_o.err   = head.err | half_err_q;  // Either word may have faulted
      end
      default: ;
    endcase
  end

  assign fetch_valid_o = fetch_valid && !pc_set_i;  // Nothing of the old stream on a redirect
  assign accept = fetch_valid_o && fetch_ready_i;
  assign split  = (state_q == HALF_PENDING) && (q_cnt_q != '0) && !upper_c;
  // Pop once the head word is fully used
  assign pop = split || (accept && ((state_q == HALF_PENDING) ||
                                    (state_q == ALIGNED && !lower_c)));

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED;
      pc_q    <= '0;
    end else if (pc_set_i) begin
      state_q <= branch_addr_i[1] ? HALF_PENDING : ALIGNED;  // Odd target drops the low half
      pc_q    <= {branch_addr_i[31:1], 1'b0};
    end else if (split) begin
      state_q <= SPLIT_WAIT;
    end else if (accept) begin
      case (state_q)
        ALIGNED: begin
          state_q <= lower_c ? HALF_PENDING : ALIGNED;
          pc_q    <= pc_q + (lower_c ? 32'd2 : 32'd4);
        end
        HALF_PENDING: begin
          state_q <= ALIGNED;
          pc_q    <= pc_q + 32'd2;
        end
        default: begin           // SPLIT_WAIT, top half of the head word comes next
          state_q <= HALF_PENDING;
          pc_q    <= pc_q + 32'd4;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (split) begin
      half_q     <= head.rdata[31:16];
      half_err_q <= head.err;
    end
  end

  assign fetch_pc_o = pc_q;
  assign busy_o     = (out_cnt_q != '0) || (q_cnt_q != '0) || stale_q;

endmodule

// ==== design/compressed_decoder.sv ====
// Expands the supported RVC subset to 32-bit encodings; combinational, used in the IF stage
`timescale 1ns/100ps

module compressed_decoder import if_pkg::*; (
  input  instr_resp_t instr_i,          // Halfword in bits 15:0 when compressed
  output instr_resp_t instr_o,
  output logic        is_compressed_o,
  output logic        illegal_c_o       // Compressed but not in the supported subset
);

  // Major opcodes of the expanded forms
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  logic [15:0] c;
  logic [4:0]  rd, rs2;
  logic [11:0] imm6;    // CI immediate, sign extended

  assign c    = instr_i.rdata[15:0];
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  assign imm6 = {{6{c[12]}}, c[12], c[6:2]};

  assign is_compressed_o = instr_i.rdata[1:0] != 2'b11;

  always_comb begin
    instr_o     = instr_i;  // Pass through by default
    illegal_c_o = 1'b0;
    if (is_compressed_o) begin
      illegal_c_o = 1'b1;   // Cleared by each supported encoding
      case ({c[15:13], c[1:0]})
        5'b000_01: begin    // C.ADDI and C.NOP, addi rd, rd, imm
          instr_o.rdata = {imm6, rd, 3'b000, rd, OPC_OP_IMM};
          illegal_c_o   = 1'b0;
        end
        5'b010_01: begin    // C.LI, addi rd, x0, imm
          instr_o.rdata = {imm6, 5'd0, 3'b000, rd, OPC_OP_IMM};
          illegal_c_o   = 1'b0;
        end
        5'b101_01: begin    // C.J, jal x0, offset
          instr_o.rdata = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           c[12], {8{c[12]}}, 5'd0, OPC_JAL};
          illegal_c_o   = 1'b0;
        end
        5'b100_10: begin
          if (!c[12] && rs2 == 5'd0 && rd != 5'd0) begin        // C.JR
            instr_o.rdata = {12'd0, rd, 3'b000, 5'd0, OPC_JALR};
            illegal_c_o   = 1'b0;
          end else if (!c[12] && rs2 != 5'd0) begin             // C.MV, add rd, x0, rs2
            instr_o.rdata = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
            illegal_c_o   = 1'b0;
          end else if (c[12] && rs2 != 5'd0) begin              // C.ADD
            instr_o.rdata = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
            illegal_c_o   = 1'b0;
          end
        end
        default: ;          // Quadrant 0, all-zero halfword and the rest
      endcase
    end
  end

endmodule

// ==== design/if_stage.sv ====
// Instruction fetch stage top; next-PC select, fetch path and IF/ID register
`timescale 1ns/100ps
`include "if_params.svh"

module if_stage import if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Redirect targets
  input  logic [31:0] boot_addr_i,
  input  logic [31:0] jump_target_i,
  input  logic [31:0] branch_target_i,
  input  logic [31:0] mepc_i,
  input  logic [24:0] mtvec_addr_i,     // mtvec base, upper bits
  input  logic [4:0]  irq_id_i,

  // Controller
  input  logic        pc_set_i,
  input  pc_mux_e     pc_mux_i,
  input  logic        halt_if_i,
  input  logic        kill_if_i,
  input  logic        id_ready_i,

  // OBI instruction bus
  output logic        instr_req_o,
  input  logic        instr_gnt_i,
  output logic [31:0] instr_addr_o,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i,

  // Toward ID
  output logic        if_valid_o,
  output logic        id_instr_valid_o,
  output logic [31:0] id_instr_o,
  output logic [31:0] id_pc_o,
  output logic        id_compressed_o,
  output logic        id_illegal_c_o,
  output logic [15:0] id_compressed_instr_o,
  output logic        id_bus_err_o,
  output logic        csr_mtvec_init_o,  // Boot redirect, CSRs init mtvec
  output logic        if_busy_o
);

  logic [31:0] branch_addr_n;
  logic        fetch_valid, if_ready;
  instr_resp_t fetch_instr, instr_decomp;
  logic [31:0] fetch_pc;
  logic        is_compressed, illegal_c;
  if_id_pipe_t if_id_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_JUMP:     branch_addr_n = jump_target_i;
      PC_BRANCH:   branch_addr_n = branch_target_i;
      PC_MRET:     branch_addr_n = mepc_i;
      PC_TRAP_EXC: branch_addr_n = {mtvec_addr_i, 7'h00};           // Shared exception entry
      PC_TRAP_IRQ: branch_addr_n = {mtvec_addr_i, irq_id_i, 2'b00}; // Vectored
      default:     branch_addr_n = boot_addr_i & `IF_PC_ALIGN_MASK; // PC_BOOT
    endcase
  end

  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  ////////////////////////////////////////////////////////////////////////////
  // Fetch path
  ////////////////////////////////////////////////////////////////////////////

  instr_trans_if trans_if ();

  prefetch_unit prefetch_unit_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i ({branch_addr_n[31:1], 1'b0}),  // Halfword aligned
    .fetch_ready_i (if_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_instr_o (fetch_instr),
    .fetch_pc_o    (fetch_pc),
    .busy_o        (if_busy_o),
    .trans         (trans_if.requester)
  );

  instr_obi_interface instr_obi_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans          (trans_if.adapter),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  compressed_decoder compressed_decoder_i (
    .instr_i         (fetch_instr),
    .instr_o         (instr_decomp),
    .is_compressed_o (is_compressed),
    .illegal_c_o     (illegal_c)
  );

  // Kill drains the held instruction, halt freezes it
  assign if_valid_o = fetch_valid && !halt_if_i && !kill_if_i;
  assign if_ready   = kill_if_i || (id_ready_i && !halt_if_i);

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      if_id_q.instr_valid      <= 1'b0;
      if_id_q.instr            <= '{rdata: `IF_NOP_INSTR, err: 1'b0};
      if_id_q.pc               <= '0;
      if_id_q.compressed       <= 1'b0;
      if_id_q.illegal_c        <= 1'b0;
      if_id_q.compressed_instr <= '0;
    end else if (if_valid_o && id_ready_i) begin
      if_id_q.instr_valid      <= 1'b1;
      if_id_q.instr            <= instr_decomp;
      if_id_q.pc               <= fetch_pc;
      if_id_q.compressed       <= is_compressed;
      if_id_q.illegal_c        <= illegal_c;
      if_id_q.compressed_instr <= fetch_instr.rdata[15:0];
    end else if (id_ready_i) begin
      if_id_q.instr_valid      <= 1'b0;  // ID took it, nothing new
    end
  end

  assign id_instr_valid_o      = if_id_q.instr_valid;
  assign id_instr_o            = if_id_q.instr.rdata;
  assign id_bus_err_o          = if_id_q.instr.err;
  assign id_pc_o               = if_id_q.pc;
  assign id_compressed_o       = if_id_q.compressed;
  assign id_illegal_c_o        = if_id_q.illegal_c;
  assign id_compressed_instr_o = if_id_q.compressed_instr;

endmodule

// ==== tests/clk_gen.sv ====
// Testbench clock and reset source; 4 ns clock, reset held low for the first 10 cycles
`timescale 1ns/100ps

module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    repeat (10) @(posedge clk_o);
    #1 rst_n_o = 1'b1;          // Release away from the edge
  end

endmodule

// ==== tests/if_stage_assert.sv ====
// Concurrent checks on the OBI and IF/ID handshakes; bound into the IF stage top
`timescale 1ns/100ps

module if_stage_assert (
  input logic        clk,
  input logic        rst_n,
  input logic        instr_req_i,
  input logic        instr_gnt_i,
  input logic [31:0] instr_addr_i,
  input logic        instr_rvalid_i,
  input logic        id_ready_i,
  input logic        id_instr_valid_i,
  input logic [31:0] id_instr_i,
  input logic [31:0] id_pc_i,
  input logic        id_bus_err_i,
  input logic        if_valid_i,
  input logic        csr_mtvec_init_i,
  input logic        if_busy_i
);

  logic [2:0] outstanding_q;  // Granted, not yet answered

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(instr_req_i && instr_gnt_i) - 3'(instr_rvalid_i);
    end
  end

  // Request and address stay put until granted
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("Request withdrawn or address changed before grant");

  resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> outstanding_q != '0)
    else $error("Response without an outstanding request");

  // ID stalled, register frozen
  pipe_stable: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable({id_instr_valid_i, id_instr_i, id_pc_i, id_bus_err_i}))
    else $error("IF/ID register changed while ID stalled");

  known_out: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({instr_req_i, if_valid_i, id_instr_valid_i, csr_mtvec_init_i, if_busy_i}))
    else $error("Unknown value on an IF output");

endmodule

bind if_stage if_stage_assert if_stage_assert_i (
  .clk              (clk),
  .rst_n            (rst_n),
  .instr_req_i      (instr_req_o),
  .instr_gnt_i      (instr_gnt_i),
  .instr_addr_i     (instr_addr_o),
  .instr_rvalid_i   (instr_rvalid_i),
  .id_ready_i       (id_ready_i),
  .id_instr_valid_i (id_instr_valid_o),
  .id_instr_i       (id_instr_o),
  .id_pc_i          (id_pc_o),
  .id_bus_err_i     (id_bus_err_o),
  .if_valid_i       (if_valid_o),
  .csr_mtvec_init_i (csr_mtvec_init_o),
  .if_busy_i        (if_busy_o)
);

// ==== tests/if_stage_tb.sv ====
// IF stage testbench; memory model, redirect table run in a loop, checks on every ID handshake
`timescale 1ns/100ps

module if_stage_tb import if_pkg::*; ();

  typedef struct packed {
    logic [31:0] raw;   // Halfword in 15:0 when compressed
    logic [31:0] exp;   // Expected word on id_instr_o
    logic        ill;
  } prog_t;

  typedef struct packed {
    pc_mux_e     src;
    logic [31:0] target;  // mtvec base in 24:0 for traps
    logic [4:0]  irq;
    logic [31:0] exp_pc;
    int          count;
    logic        bp;      // Random stall and halt spans
    logic        kill;
  } test_t;

  localparam int NI = 17;
  localparam int NT = 8;

  // Program image packed from 0x100
  prog_t prog [NI] = '{
    '{32'h00100093, 32'h00100093, 1'b0}, '{32'h00208113, 32'h00208113, 1'b0},
    '{32'h00000505, 32'h00150513, 1'b0},  // C.ADDI x10, 1
    '{32'h00004185, 32'h00100193, 1'b0},  // C.LI x3, 1
    '{32'h00000001, 32'h00000013, 1'b0},  // C.NOP
    '{32'h00300213, 32'h00300213, 1'b0},  // Split over two words
    '{32'h0000852e, 32'h00b00533, 1'b0},  // C.MV
    '{32'h0000952e, 32'h00b50533, 1'b0},  // C.ADD
    '{32'h00008082, 32'h00008067, 1'b0},  // C.JR x1
    '{32'h0000a011, 32'h0040006f, 1'b0},  // C.J +4
    '{32'h00000000, 32'h00000000, 1'b1},  // All-zero halfword
    '{32'h00006105, 32'h00006105, 1'b1},  // C.ADDI16SP is not supported
    '{32'h00500293, 32'h00500293, 1'b0}, '{32'h00600313, 32'h00600313, 1'b0},
    '{32'h00000505, 32'h00150513, 1'b0},
    '{32'h00700393, 32'h00700393, 1'b0}, '{32'h00800413, 32'h00800413, 1'b0}
  };

  test_t tests [NT] = '{
    '{PC_BOOT,     32'h103, 5'd0, 32'h100, 17, 1'b0, 1'b0},
    '{PC_JUMP,     32'h10e, 5'd0, 32'h10e, 3,  1'b0, 1'b0},  // Odd halfword target
    '{PC_BRANCH,   32'h118, 5'd0, 32'h118, 2,  1'b0, 1'b0},
    '{PC_MRET,     32'h128, 5'd0, 32'h128, 2,  1'b0, 1'b0},
    '{PC_TRAP_EXC, 32'h002, 5'd0, 32'h100, 2,  1'b0, 1'b0},
    '{PC_TRAP_IRQ, 32'h002, 5'd3, 32'h10c, 3,  1'b0, 1'b0},
    '{PC_BOOT,     32'h114, 5'd0, 32'h114, 8,  1'b1, 1'b0},
    '{PC_BOOT,     32'h100, 5'd0, 32'h100, 3,  1'b0, 1'b1}
  };

  logic        clk, rst_n;
  logic [31:0] boot_addr_i, jump_target_i, branch_target_i, mepc_i;
  logic [24:0] mtvec_addr_i;
  logic [4:0]  irq_id_i;
  logic        pc_set_i, halt_if_i, kill_if_i, id_ready_i;
  pc_mux_e     pc_mux_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        if_valid_o, id_instr_valid_o, id_compressed_o, id_illegal_c_o;
  logic [31:0] id_instr_o, id_pc_o;
  logic [15:0] id_compressed_instr_o;
  logic        id_bus_err_o, csr_mtvec_init_o, if_busy_o;

  logic [15:0] img [512];      // Halfword image of 1 KB
  logic [31:0] ins_addr [NI];
  logic [31:0] rq_addr [$];    // Granted requests in order
  int          rq_wait [$];
  int          errors, checks;

  clk_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

  if_stage dut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic word_err(input logic [31:0] a);
    return a[31:2] == 30'h48;  // Word 0x120 faults
  endfunction

  initial begin
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && instr_req_o && instr_gnt_i) begin  // Grant at the coming edge
        rq_addr.push_back(instr_addr_o);
        rq_wait.push_back(1 + int'($urandom % 3));
      end
      @(posedge clk);
      #1;
      instr_gnt_i    = ($urandom % 3) != 0;
      instr_rvalid_i = 1'b0;
      if (rq_wait.size() != 0) begin
        rq_wait[0] = rq_wait[0] - 1;
        if (rq_wait[0] == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = {img[{rq_addr[0][9:2], 1'b1}], img[{rq_addr[0][9:2], 1'b0}]};
          instr_err_i    = word_err(rq_addr[0]);
          void'(rq_addr.pop_front());
          void'(rq_wait.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_word(input instr_resp_t got, input instr_resp_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h err %b, expected %h err %b", $time, what,
               got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_half(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    test_t       e;
    int          idx, got_n, err0;
    logic        c;
    instr_resp_t exp;
    e    = tests[t];
    err0 = errors;
    idx  = -1;
    @(posedge clk);
    #1;
    boot_addr_i     = e.target;
    jump_target_i   = e.target;
    branch_target_i = e.target;
    mepc_i          = e.target;
    mtvec_addr_i    = e.target[24:0];
    irq_id_i        = e.irq;
    pc_mux_i        = e.src;
    pc_set_i        = 1'b1;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    @(negedge clk);
    compare_flag(csr_mtvec_init_o, e.src == PC_BOOT, "csr_mtvec_init_o");
    @(posedge clk);
    #1 pc_set_i = 1'b0;
    for (int i = 0; i < NI; i++) if (ins_addr[i] == e.exp_pc) idx = i;
    if (idx < 0) begin
      errors++;
      $display("Test %0d has a start address outside the program", t);
      return;
    end
    if (e.kill) begin  // Hold the first instruction, then kill it
      id_ready_i = 1'b0;
      @(negedge clk);
      while (!if_valid_o) @(negedge clk);
      @(posedge clk);
      #1 kill_if_i = 1'b1;
      @(posedge clk);
      #1;
      kill_if_i  = 1'b0;
      id_ready_i = 1'b1;
      idx++;
    end
    got_n = 0;
    while (got_n < e.count) begin
      @(posedge clk);
      #1;
      if (e.bp) begin
        id_ready_i = ($urandom % 3) != 0;
        halt_if_i  = ($urandom % 4) == 0;
      end
      @(negedge clk);
      if (id_instr_valid_o && id_ready_i) begin  // ID takes it at the next edge
        c   = prog[idx].raw[1:0] != 2'b11;
        exp = '{rdata: prog[idx].exp,
                err: word_err(ins_addr[idx]) ||
                     (!c && ins_addr[idx][1] && word_err(ins_addr[idx] + 32'd2))};
        compare_word('{rdata: id_instr_o, err: id_bus_err_o}, exp, "id_instr_o");
        compare_pc(id_pc_o, ins_addr[idx], "id_pc_o");
        compare_flag(id_compressed_o, c, "id_compressed_o");
        compare_flag(id_illegal_c_o, prog[idx].ill, "id_illegal_c_o");
        compare_half(id_compressed_instr_o, prog[idx].raw[15:0], "id_compressed_instr_o");
        compare_flag(csr_mtvec_init_o, 1'b0, "csr_mtvec_init_o");
        idx++;
        got_n++;
      end
    end
    $display("test %0d %s: %0d instructions, %0d mismatches", t, e.src.name(), got_n,
             errors - err0);
  endtask

  // Watchdog allows 40 cycles per instruction plus slack
  initial begin
    int total;
    total = 0;
    for (int t = 0; t < NT; t++) total += tests[t].count;
    repeat (total * 40 + 500) @(posedge clk);
    $display("Timeout: the run did not finish in time");
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] a;
    void'($urandom(91));
    {boot_addr_i, jump_target_i, branch_target_i, mepc_i} = '0;
    mtvec_addr_i = '0;
    irq_id_i     = '0;
    pc_mux_i     = PC_BOOT;
    pc_set_i     = 1'b0;
    halt_if_i    = 1'b0;
    kill_if_i    = 1'b0;
    id_ready_i   = 1'b1;
    errors       = 0;
    checks       = 0;
    for (int w = 0; w < 256; w++) begin  // Fill with addi words carrying the address
      a = 32'(w) << 2;
      {img[2*w+1], img[2*w]} = {a[24:0], 7'h13};
    end
    a = 32'h100;
    for (int i = 0; i < NI; i++) begin
      ins_addr[i]   = a;
      img[a[9:1]]   = prog[i].raw[15:0];
      if (prog[i].raw[1:0] == 2'b11) img[a[9:1] + 9'd1] = prog[i].raw[31:16];
      a = a + ((prog[i].raw[1:0] == 2'b11) ? 32'd4 : 32'd2);
    end
    wait (rst_n);
    @(negedge clk);
    // No fetch and nothing toward ID before the first redirect
    compare_flag(instr_req_o, 1'b0, "instr_req_o after reset");
    compare_flag(if_valid_o, 1'b0, "if_valid_o after reset");
    compare_flag(id_instr_valid_o, 1'b0, "id_instr_valid_o after reset");
    compare_flag(csr_mtvec_init_o, 1'b0, "csr_mtvec_init_o after reset");
    compare_flag(if_busy_o, 1'b0, "if_busy_o after reset");
    for (int t = 0; t < NT; t++) run_test(t);
    $display("Summary: %0d tests, %0d checks, %0d errors", NT, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+design
design/if_pkg.sv
design/instr_trans_if.sv
design/instr_obi_interface.sv
design/prefetch_unit.sv
design/compressed_decoder.sv
design/if_stage.sv
tests/clk_gen.sv
tests/if_stage_assert.sv
tests/if_stage_tb.sv

// ==== Makefile ====
TOP = if_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
